/* hw/jsp_params.svh */
//////////////////////////////////////////////////
// Sizing constants for the JTAG serial port bridge
// Included by the package and by sized RTL blocks
//////////////////////////////////////////////////

`ifndef JSP_PARAMS_SVH
`define JSP_PARAMS_SVH

// Bytes held by each direction FIFO
`define JSP_FIFO_DEPTH 8

// Width of the avail/free counts, wide enough for 0..depth
`define JSP_CNT_W 4

// 16550 register address width
`define JSP_ADDR_W 3

`endif

/* hw/jsp_pkg.sv */
//////////////////////////////////////////////////
// Shared types for the JTAG serial port bridge
//////////////////////////////////////////////////

`include "jsp_params.svh"

package jsp_pkg;

  // One data byte on either side of the bridge
  typedef logic [7:0] jsp_byte_t;

  // FIFO occupancy or free space, 0 up to the depth
  typedef logic [`JSP_CNT_W-1:0] jsp_cnt_t;

  // 16550 register map
  typedef enum logic [`JSP_ADDR_W-1:0] {
    REG_DATA    = 3'd0,
    REG_IER     = 3'd1,
    REG_IIR_FCR = 3'd2,
    REG_LCR     = 3'd3,
    REG_MCR     = 3'd4,
    REG_LSR     = 3'd5,
    REG_MSR     = 3'd6,
    REG_SCR     = 3'd7
  } jsp_reg_e;

  // Interrupt identification codes, bit 0 set means nothing pending
  typedef enum logic [7:0] {
    IIR_NONE = 8'h01,
    IIR_THRE = 8'h02,
    IIR_RDA  = 8'h04
  } jsp_iir_e;

endpackage

/* hw/jsp_fifo_if.sv */
//////////////////////////////////////////////////
// Bundle of one byte FIFO's control, data and counts
//////////////////////////////////////////////////

`include "jsp_params.svh"

interface jsp_fifo_if ();

  // Requests toward the store
  logic                  push;
  logic                  pop;
  logic                  flush;
  logic [7:0]            wdata;

  // Store state, all in the PCLK domain
  logic [7:0]            head;
  logic [`JSP_CNT_W-1:0] avail;
  logic [`JSP_CNT_W-1:0] free;

  // Controller moves bytes in and out
  modport ctrl  (output push, pop, wdata, input head, avail, free);
  // Register block flushes and watches the state
  modport regs  (output flush, input pop, head, avail, free);
  // The FIFO itself
  modport store (input push, pop, flush, wdata, output head, avail, free);

endinterface

/* hw/jsp_byte_fifo.sv */
//////////////////////////////////////////////////
// Byte FIFO in PCLK, one per bridge direction
// Flush clears it at once, head is the oldest byte
//////////////////////////////////////////////////

`include "jsp_params.svh"

module jsp_byte_fifo
  import jsp_pkg::*;
(
  input logic          PCLK,
  input logic          PRESETn,
  jsp_fifo_if.store    fifo_if
);

  localparam int PTR_W = $clog2(`JSP_FIFO_DEPTH);
  localparam jsp_cnt_t DEPTH_CNT = jsp_cnt_t'(`JSP_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`JSP_FIFO_DEPTH - 1);

  // Storage array
  jsp_byte_t        mem [`JSP_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  jsp_cnt_t         count;
  logic             do_push;
  logic             do_pop;

  // Full push and empty pop fall away here
  assign do_push = fifo_if.push && (count != DEPTH_CNT);
  assign do_pop  = fifo_if.pop && (count != '0);

  // Pointers and occupancy, flush acts without waiting for the edge
  always_ff @(posedge PCLK or negedge PRESETn or posedge fifo_if.flush) begin
    if (!PRESETn || fifo_if.flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the count alone
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Data array write
  always_ff @(posedge PCLK) begin
    if (do_push) begin
      mem[wr_ptr] <= fifo_if.wdata;
    end
  end

  // Oldest entry, no read latency
  assign fifo_if.head  = mem[rd_ptr];
  assign fifo_if.avail = count;
  assign fifo_if.free  = DEPTH_CNT - count;

endmodule

/* hw/jsp_tck_port.sv */
//////////////////////////////////////////////////
// Debug-side port in TCK, strobe toggles and data
// capture out, Gray-synchronised counts back in
//////////////////////////////////////////////////

`include "jsp_params.svh"

module jsp_tck_port
  import jsp_pkg::*;
(
  input  logic      tck_i,
  input  logic      PRESETn,
  input  jsp_byte_t data_i,
  input  logic      wr_strobe_i,
  input  logic      rd_strobe_i,
  input  jsp_cnt_t  rx_free_i,
  input  jsp_cnt_t  tx_avail_i,
  output logic      wen_tgl_o,
  output logic      ren_tgl_o,
  output jsp_byte_t tck_wdata_o,
  output jsp_cnt_t  bytes_free_o,
  output jsp_cnt_t  bytes_available_o
);

  // Gray image of a full free count, so the debug side sees 8 out of reset
  localparam jsp_cnt_t DEPTH_CNT     = jsp_cnt_t'(`JSP_FIFO_DEPTH);
  localparam jsp_cnt_t FREE_GRAY_RST = DEPTH_CNT ^ (DEPTH_CNT >> 1);

  jsp_cnt_t free_gray;
  jsp_cnt_t avail_gray;
  jsp_cnt_t free_s1;
  jsp_cnt_t free_s2;
  jsp_cnt_t avail_s1;
  jsp_cnt_t avail_s2;

  function automatic jsp_cnt_t gray2bin(jsp_cnt_t g);
    jsp_cnt_t b;
    b[`JSP_CNT_W-1] = g[`JSP_CNT_W-1];
    for (int i = `JSP_CNT_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  //////////////////////////////////////////////////
  // Strobes into toggles
  //////////////////////////////////////////////////

  // Each strobe flips its toggle, PCLK side looks for the edge
  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      wen_tgl_o <= 1'b0;
      ren_tgl_o <= 1'b0;
    end else begin
      if (wr_strobe_i) begin
        wen_tgl_o <= ~wen_tgl_o;
      end
      if (rd_strobe_i) begin
        ren_tgl_o <= ~ren_tgl_o;
      end
    end
  end

  // Byte stays put until the next strobe, long after the toggle lands
  always_ff @(posedge tck_i) begin
    if (wr_strobe_i) begin
      tck_wdata_o <= data_i;
    end
  end

  //////////////////////////////////////////////////
  // Counts into TCK
  //////////////////////////////////////////////////

  // Counts move by one per PCLK step, so one Gray bit changes at a time
  assign free_gray  = rx_free_i ^ (rx_free_i >> 1);
  assign avail_gray = tx_avail_i ^ (tx_avail_i >> 1);

  always_ff @(posedge tck_i or negedge PRESETn) begin
    if (!PRESETn) begin
      free_s1  <= FREE_GRAY_RST;
      free_s2  <= FREE_GRAY_RST;
      avail_s1 <= '0;
      avail_s2 <= '0;
    end else begin
      free_s1  <= free_gray;
      free_s2  <= free_s1;
      avail_s1 <= avail_gray;
      avail_s2 <= avail_s1;
    end
  end

  assign bytes_free_o      = gray2bin(free_s2);
  assign bytes_available_o = gray2bin(avail_s2);

endmodule

/* hw/jsp_fifo_ctrl.sv */
//////////////////////////////////////////////////
// PCLK-side FIFO control, toggle sync, rx/tx FSMs
// and the data_o holding register for the debug side
//////////////////////////////////////////////////

module jsp_fifo_ctrl
  import jsp_pkg::*;
(
  input  logic      PCLK,
  input  logic      PRESETn,
  input  logic      wen_tgl_i,
  input  logic      ren_tgl_i,
  input  jsp_byte_t tck_wdata_i,
  input  logic      bus_rd_req_i,
  input  logic      bus_wr_req_i,
  input  jsp_byte_t PWDATA_i,
  output logic      data_ack_o,
  output jsp_byte_t data_o,
  output jsp_cnt_t  rx_free_o,
  output jsp_cnt_t  tx_avail_o,
  jsp_fifo_if.ctrl  rx_if,
  jsp_fifo_if.ctrl  tx_if
);

  typedef enum logic [1:0] {RX_IDLE, RX_PUSH, RX_POP} rx_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_PUSH, TX_POP, TX_LOAD} tx_state_e;

  rx_state_e  rx_state;
  rx_state_e  rx_next;
  tx_state_e  tx_state;
  tx_state_e  tx_next;
  logic [2:0] wen_sync;
  logic [2:0] ren_sync;
  logic       wen_edge;
  logic       ren_edge;
  // Work waiting for an FSM slot
  logic       wen_pend;
  logic       ren_pend;
  logic       rd_pend;
  logic       wr_pend;

  //////////////////////////////////////////////////
  // Toggle sync and pending flags
  //////////////////////////////////////////////////

  // Two flops to settle, third to find the toggle edge
  assign wen_edge = wen_sync[2] ^ wen_sync[1];
  assign ren_edge = ren_sync[2] ^ ren_sync[1];

  // A new request beats the clear of an old one
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      wen_sync <= '0;
      ren_sync <= '0;
      wen_pend <= 1'b0;
      ren_pend <= 1'b0;
      rd_pend  <= 1'b0;
      wr_pend  <= 1'b0;
    end else begin
      wen_sync <= {wen_sync[1:0], wen_tgl_i};
      ren_sync <= {ren_sync[1:0], ren_tgl_i};
      wen_pend <= wen_edge | (wen_pend & (rx_state != RX_PUSH));
      rd_pend  <= bus_rd_req_i | (rd_pend & (rx_state != RX_POP));
      wr_pend  <= bus_wr_req_i | (wr_pend & (tx_state != TX_PUSH));
      ren_pend <= ren_edge | (ren_pend & (tx_state != TX_POP));
    end
  end

  //////////////////////////////////////////////////
  // State machines
  //////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      rx_state <= RX_IDLE;
      tx_state <= TX_IDLE;
    end else begin
      rx_state <= rx_next;
      tx_state <= tx_next;
    end
  end

  // Rx, bus reads first; a state never looks at the flag it is clearing
  always_comb begin
    rx_next = RX_IDLE;
    case (rx_state)
      RX_IDLE: begin
        if (rd_pend) begin
          rx_next = RX_POP;
        end else if (wen_pend) begin
          rx_next = RX_PUSH;
        end
      end
      RX_PUSH: rx_next = rd_pend ? RX_POP : RX_IDLE;
      RX_POP:  rx_next = wen_pend ? RX_PUSH : RX_IDLE;
      default: rx_next = RX_IDLE;
    endcase
  end

  // Tx, bus writes first, head reload after a pop or a first byte
  always_comb begin
    tx_next = TX_IDLE;
    case (tx_state)
      TX_IDLE, TX_LOAD: begin
        if (wr_pend) begin
          tx_next = TX_PUSH;
        end else if (ren_pend) begin
          tx_next = TX_POP;
        end
      end
      TX_PUSH: begin
        if (tx_if.avail == '0) begin
          tx_next = TX_LOAD;
        end else if (ren_pend) begin
          tx_next = TX_POP;
        end
      end
      TX_POP:  tx_next = TX_LOAD;
      default: tx_next = TX_IDLE;
    endcase
  end

  // FIFO strobes; head still valid during the pop cycle for PRDATA
  assign rx_if.push  = (rx_state == RX_PUSH);
  assign rx_if.pop   = (rx_state == RX_POP);
  assign rx_if.wdata = tck_wdata_i;
  assign tx_if.push  = (tx_state == TX_PUSH);
  assign tx_if.pop   = (tx_state == TX_POP);
  // PWDATA holds for the whole APB transfer
  assign tx_if.wdata = PWDATA_i;

  // Ends the data port access phase
  assign data_ack_o = rx_if.pop | tx_if.push;

  // Byte shown to the debug side
  always_ff @(posedge PCLK) begin
    if (tx_state == TX_LOAD) begin
      data_o <= tx_if.head;
    end
  end

  assign rx_free_o  = rx_if.free;
  assign tx_avail_o = tx_if.avail;

endmodule

/* hw/jsp_uart_regs.sv */
//////////////////////////////////////////////////
// 16550-style register block on APB, decode,
// handshake, FIFO flush, IIR and interrupt
//////////////////////////////////////////////////

module jsp_uart_regs
  import jsp_pkg::*;
(
  input  logic      PCLK,
  input  logic      PRESETn,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  logic      PWRITE,
  input  jsp_reg_e  PADDR,
  input  jsp_byte_t PWDATA,
  output jsp_byte_t PRDATA,
  output logic      PREADY,
  output logic      PSLVERR,
  output logic      bus_rd_req_o,
  output logic      bus_wr_req_o,
  output logic      int_o,
  input  logic      data_ack_i,
  jsp_fifo_if.regs  rx_if,
  jsp_fifo_if.regs  tx_if
);

  // Modem status is not modelled
  localparam jsp_byte_t MSR_VAL = 8'h0b;

  logic [3:0] ier;
  jsp_byte_t  lcr;
  jsp_byte_t  scr;
  jsp_byte_t  lsr;
  jsp_iir_e   iir;
  logic       setup;
  logic       access;
  logic       data_sel;
  logic       reg_ack;
  logic       reg_wr;
  logic       fcr_setup;
  logic       flush_rx_q;
  logic       flush_tx_q;
  logic       iir_read;
  logic       thr_arm;
  logic       rx_empty;
  logic       tx_not_full;

  //////////////////////////////////////////////////
  // Decode and handshake
  //////////////////////////////////////////////////

  assign setup  = PSEL & ~PENABLE;
  assign access = PSEL & PENABLE;

  // Data port only reachable with DLAB clear
  assign data_sel     = (PADDR == REG_DATA) & ~lcr[7];
  assign bus_rd_req_o = setup & ~PWRITE & data_sel;
  assign bus_wr_req_o = setup & PWRITE & data_sel;

  // Everything but the data port answers in the first access cycle
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      reg_ack <= 1'b0;
    end else begin
      reg_ack <= setup & ~data_sel;
    end
  end

  assign PREADY  = reg_ack | data_ack_i;
  assign PSLVERR = 1'b0;

  //////////////////////////////////////////////////
  // Writable registers and FCR
  //////////////////////////////////////////////////

  assign reg_wr = access & PWRITE & reg_ack;

  // IER locked out while DLAB is set, DLAB data writes just vanish
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      ier <= '0;
      lcr <= '0;
      scr <= '0;
    end else if (reg_wr) begin
      case (PADDR)
        REG_IER: begin
          if (!lcr[7]) begin
            ier <= PWDATA[3:0];
          end
        end
        REG_LCR: lcr <= PWDATA;
        REG_SCR: scr <= PWDATA;
        default: begin
        end
      endcase
    end
  end

  // Flush strobes taken at setup, held high through the access cycle
  assign fcr_setup = setup & PWRITE & (PADDR == REG_IIR_FCR);

  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      flush_rx_q <= 1'b0;
      flush_tx_q <= 1'b0;
    end else begin
      flush_rx_q <= fcr_setup & PWDATA[1];
      flush_tx_q <= fcr_setup & PWDATA[2];
    end
  end

  assign rx_if.flush = flush_rx_q;
  assign tx_if.flush = flush_tx_q;

  //////////////////////////////////////////////////
  // Status, IIR and interrupt
  //////////////////////////////////////////////////

  assign rx_empty    = (rx_if.avail == '0);
  assign tx_not_full = (tx_if.free != '0);
  // THRE and TEMT both track tx space, DR tracks rx data
  assign lsr         = {1'b0, tx_not_full, tx_not_full, 4'h0, ~rx_empty};
  assign iir_read    = access & ~PWRITE & (PADDR == REG_IIR_FCR);

  // Transmit interrupt arm, set by a write or by draining tx
  always_ff @(posedge PCLK or negedge PRESETn) begin
    if (!PRESETn) begin
      thr_arm <= 1'b0;
    end else if (bus_wr_req_o || (tx_if.pop && tx_if.avail == jsp_cnt_t'(1))) begin
      thr_arm <= 1'b1;
    end else if (iir_read && rx_empty) begin
      thr_arm <= 1'b0;
    end
  end

  // Received data outranks transmit empty
  always_comb begin
    if (!rx_empty && ier[0]) begin
      iir = IIR_RDA;
    end else if (thr_arm && tx_not_full && ier[1]) begin
      iir = IIR_THRE;
    end else begin
      iir = IIR_NONE;
    end
  end

  assign int_o = (iir != IIR_NONE);

  // Read mux, divisor latch slot reads zero under DLAB
  always_comb begin
    case (PADDR)
      REG_DATA:    PRDATA = lcr[7] ? 8'h00 : rx_if.head;
      REG_IER:     PRDATA = {4'h0, ier};
      REG_IIR_FCR: PRDATA = iir;
      REG_LCR:     PRDATA = lcr;
      REG_MCR:     PRDATA = 8'h00;
      REG_LSR:     PRDATA = lsr;
      REG_MSR:     PRDATA = MSR_VAL;
      REG_SCR:     PRDATA = scr;
      default:     PRDATA = 8'h00;
    endcase
  end

endmodule

/* hw/jsp_bridge_top.sv */
//////////////////////////////////////////////////
// JTAG serial port bridge top, debug port on TCK
// and a 16550-style APB slave on PCLK
//////////////////////////////////////////////////

module jsp_bridge_top
  import jsp_pkg::*;
(
  // Debug side
  input  logic      tck_i,
  input  jsp_byte_t data_i,
  output jsp_byte_t data_o,
  output jsp_cnt_t  bytes_available_o,
  output jsp_cnt_t  bytes_free_o,
  input  logic      rd_strobe_i,
  input  logic      wr_strobe_i,
  // APB side
  input  logic      PCLK,
  input  logic      PRESETn,
  input  logic      PSEL,
  input  logic      PENABLE,
  input  logic      PWRITE,
  input  jsp_reg_e  PADDR,
  input  jsp_byte_t PWDATA,
  output jsp_byte_t PRDATA,
  output logic      PREADY,
  output logic      PSLVERR,
  output logic      int_o
);

  jsp_byte_t tck_wdata;
  jsp_cnt_t  rx_free;
  jsp_cnt_t  tx_avail;
  logic      wen_tgl;
  logic      ren_tgl;
  logic      bus_rd_req;
  logic      bus_wr_req;
  logic      data_ack;

  // Debug to bus and bus to debug byte paths
  jsp_fifo_if rx_if ();
  jsp_fifo_if tx_if ();

  jsp_byte_fifo u_rx_fifo (.PCLK(PCLK), .PRESETn(PRESETn), .fifo_if(rx_if.store));
  jsp_byte_fifo u_tx_fifo (.PCLK(PCLK), .PRESETn(PRESETn), .fifo_if(tx_if.store));

  jsp_tck_port u_tck_port (
    .tck_i            (tck_i),
    .PRESETn          (PRESETn),
    .data_i           (data_i),
    .wr_strobe_i      (wr_strobe_i),
    .rd_strobe_i      (rd_strobe_i),
    .rx_free_i        (rx_free),
    .tx_avail_i       (tx_avail),
    .wen_tgl_o        (wen_tgl),
    .ren_tgl_o        (ren_tgl),
    .tck_wdata_o      (tck_wdata),
    .bytes_free_o     (bytes_free_o),
    .bytes_available_o(bytes_available_o)
  );

  jsp_fifo_ctrl u_ctrl (
    .PCLK(PCLK), .PRESETn(PRESETn),
    .wen_tgl_i(wen_tgl), .ren_tgl_i(ren_tgl), .tck_wdata_i(tck_wdata),
    .bus_rd_req_i(bus_rd_req), .bus_wr_req_i(bus_wr_req), .PWDATA_i(PWDATA),
    .data_ack_o(data_ack), .data_o(data_o), .rx_free_o(rx_free), .tx_avail_o(tx_avail),
    .rx_if(rx_if.ctrl), .tx_if(tx_if.ctrl)
  );

  jsp_uart_regs u_regs (
    .PCLK(PCLK), .PRESETn(PRESETn), .PSEL(PSEL), .PENABLE(PENABLE),
    .PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
    .PREADY(PREADY), .PSLVERR(PSLVERR),
    .bus_rd_req_o(bus_rd_req), .bus_wr_req_o(bus_wr_req), .int_o(int_o),
    .data_ack_i(data_ack), .rx_if(rx_if.regs), .tx_if(tx_if.regs)
  );

endmodule

/* verification/jsp_tb.sv */
//////////////////////////////////////////////////
// Self-checking testbench for the JTAG serial port bridge
// Drives APB and the debug port and checks against model queues
//////////////////////////////////////////////////

`include "jsp_params.svh"

module jsp_tb
  import jsp_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DEPTH = `JSP_FIFO_DEPTH;
  // About five times the longest run of all the tests
  localparam int TIMEOUT_CYC = 20000;
  // Longest lag of the debug-side counts in TCK cycles
  localparam int SETTLE_TCK = 16;
  localparam logic [1:0] K_BYTE = 2'd0;
  localparam logic [1:0] K_CNT  = 2'd1;
  localparam logic [1:0] K_BIT  = 2'd2;

  logic      PCLK;
  logic      PRESETn;
  logic      tck_i;
  logic      PSEL;
  logic      PENABLE;
  logic      PWRITE;
  jsp_reg_e  PADDR;
  jsp_byte_t PWDATA;
  jsp_byte_t PRDATA;
  logic      PREADY;
  logic      PSLVERR;
  logic      int_o;
  jsp_byte_t data_i;
  jsp_byte_t data_o;
  jsp_cnt_t  bytes_available_o;
  jsp_cnt_t  bytes_free_o;
  logic      rd_strobe_i;
  logic      wr_strobe_i;

  // Reference model state
  jsp_byte_t  rx_q[$];
  jsp_byte_t  tx_q[$];
  logic [3:0] model_ier;
  jsp_byte_t  model_lcr;
  jsp_byte_t  model_scr;
  logic       model_arm;
  int         seed;
  int         cycles;

  // Results waiting for the compare process
  logic [1:0] kind_mem [64];
  string      name_mem [64];
  logic [7:0] exp_mem [64];
  logic [7:0] got_mem [64];
  logic [5:0] wr_idx;
  logic [5:0] rd_idx;

  jsp_bridge_top u_dut (.*);

  always #4 PCLK = ~PCLK;
  always #13 tck_i = ~tck_i;

  //////////////////////////////////////////////////
  // Reference, checks and failure
  //////////////////////////////////////////////////

  // Expected {IIR, LSR} from the 16550 rules of the bridge
  function automatic logic [15:0] ref_status(int rx_n, int tx_n, logic [3:0] ier_v,
                                             logic arm_v);
    jsp_byte_t lsr_v;
    jsp_byte_t iir_v;
    lsr_v    = 8'h00;
    lsr_v[0] = (rx_n != 0);
    lsr_v[5] = (tx_n < DEPTH);
    lsr_v[6] = (tx_n < DEPTH);
    if (rx_n != 0 && ier_v[0]) begin
      iir_v = IIR_RDA;
    end else if (arm_v && tx_n < DEPTH && ier_v[1]) begin
      iir_v = IIR_THRE;
    end else begin
      iir_v = IIR_NONE;
    end
    return {iir_v, lsr_v};
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_byte(string name, jsp_byte_t exp, jsp_byte_t got);
    if (got !== exp) begin
      fail_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_cnt(string name, jsp_cnt_t exp, jsp_cnt_t got);
    if (got !== exp) begin
      fail_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(string name, logic exp, logic got);
    if (got !== exp) begin
      fail_run($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic post(logic [1:0] kind, string name, logic [7:0] exp, logic [7:0] got);
    kind_mem[wr_idx] = kind;
    name_mem[wr_idx] = name;
    exp_mem[wr_idx]  = exp;
    got_mem[wr_idx]  = got;
    wr_idx = wr_idx + 1'b1;
  endtask

  // Compare process draining posted results every cycle
  always @(negedge PCLK) begin
    while (rd_idx != wr_idx) begin
      case (kind_mem[rd_idx])
        K_BYTE:  check_byte(name_mem[rd_idx], exp_mem[rd_idx], got_mem[rd_idx]);
        K_CNT:   check_cnt(name_mem[rd_idx], jsp_cnt_t'(exp_mem[rd_idx]),
                           jsp_cnt_t'(got_mem[rd_idx]));
        default: check_bit(name_mem[rd_idx], exp_mem[rd_idx][0], got_mem[rd_idx][0]);
      endcase
      rd_idx = rd_idx + 1'b1;
    end
  end

  always @(posedge PCLK) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      fail_run("Timeout, the DUT stopped answering before the tests finished");
    end
  end

  //////////////////////////////////////////////////
  // Bus and debug port drivers
  //////////////////////////////////////////////////

  // One APB transfer that waits out the access phase on PREADY
  task automatic apb_xfer(input logic wr, input jsp_reg_e addr, input jsp_byte_t wdata,
                          output jsp_byte_t rdata);
    @(negedge PCLK);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = wr;
    PADDR   = addr;
    PWDATA  = wdata;
    @(negedge PCLK);
    PENABLE = 1'b1;
    while (!PREADY) begin
      @(negedge PCLK);
    end
    rdata = PRDATA;
    post(K_BIT, "PSLVERR", 8'h00, {7'h0, PSLVERR});
    @(negedge PCLK);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  // Bus write plus the model update it implies
  task automatic bus_write(jsp_reg_e addr, jsp_byte_t d);
    jsp_byte_t unused;
    apb_xfer(1'b1, addr, d, unused);
    case (addr)
      REG_DATA: begin
        if (!model_lcr[7]) begin
          if (tx_q.size() < DEPTH) begin
            tx_q.push_back(d);
          end
          model_arm = 1'b1;
        end
      end
      REG_IER: begin
        if (!model_lcr[7]) begin
          model_ier = d[3:0];
        end
      end
      REG_IIR_FCR: begin
        if (d[1]) begin
          rx_q.delete();
        end
        if (d[2]) begin
          tx_q.delete();
        end
      end
      REG_LCR: model_lcr = d;
      REG_SCR: model_scr = d;
      default: begin
      end
    endcase
  endtask

  task automatic read_expect(jsp_reg_e addr, string name, jsp_byte_t exp,
                             output jsp_byte_t got);
    apb_xfer(1'b0, addr, 8'h00, got);
    post(K_BYTE, name, exp, got);
  endtask

  task automatic check_lsr(output jsp_byte_t v);
    logic [15:0] s;
    s = ref_status(rx_q.size(), tx_q.size(), model_ier, model_arm);
    read_expect(REG_LSR, "LSR", s[7:0], v);
  endtask

  // int_o goes first as the IIR read itself may clear the arm
  task automatic check_status();
    logic [15:0] s;
    jsp_byte_t   v;
    s = ref_status(rx_q.size(), tx_q.size(), model_ier, model_arm);
    post(K_BIT, "int_o", {7'h0, s[15:8] != IIR_NONE}, {7'h0, int_o});
    read_expect(REG_IIR_FCR, "IIR", s[15:8], v);
    if (rx_q.size() == 0) begin
      model_arm = 1'b0;
    end
    check_lsr(v);
  endtask

  // Debug counts get a bounded wait to catch up with the model
  task automatic settle();
    int waited;
    waited = 0;
    while ((bytes_available_o != jsp_cnt_t'(tx_q.size()) ||
            bytes_free_o != jsp_cnt_t'(DEPTH - rx_q.size())) &&
           waited < SETTLE_TCK) begin
      @(negedge tck_i);
      waited++;
    end
    post(K_CNT, "bytes_available_o", 8'(tx_q.size()), 8'(bytes_available_o));
    post(K_CNT, "bytes_free_o", 8'(DEPTH - rx_q.size()), 8'(bytes_free_o));
  endtask

  task automatic rx_push(jsp_byte_t b);
    @(negedge tck_i);
    data_i      = b;
    wr_strobe_i = 1'b1;
    @(negedge tck_i);
    wr_strobe_i = 1'b0;
    rx_q.push_back(b);
    settle();
  endtask

  // Debug side reads every tx byte in order
  task automatic drain_tx();
    while (tx_q.size() != 0) begin
      settle();
      post(K_BYTE, "data_o", tx_q[0], data_o);
      @(negedge tck_i);
      rd_strobe_i = 1'b1;
      @(negedge tck_i);
      rd_strobe_i = 1'b0;
      tx_q.delete(0);
      if (tx_q.size() == 0) begin
        model_arm = 1'b1;
      end
    end
    settle();
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    jsp_byte_t v;
    int        i;
    PCLK        = 1'b0;
    tck_i       = 1'b0;
    PRESETn     = 1'b0;
    PSEL        = 1'b0;
    PENABLE     = 1'b0;
    PWRITE      = 1'b0;
    PADDR       = REG_DATA;
    PWDATA      = 8'h00;
    data_i      = 8'h00;
    rd_strobe_i = 1'b0;
    wr_strobe_i = 1'b0;
    model_ier   = 4'h0;
    model_lcr   = 8'h00;
    model_scr   = 8'h00;
    model_arm   = 1'b0;
    seed        = 32'h0dae_f8eb;
    cycles      = 0;
    wr_idx      = '0;
    rd_idx      = '0;
    repeat (2) @(posedge PCLK);
    @(negedge PCLK);
    PRESETn = 1'b1;

    // Reset values on both sides
    @(negedge tck_i);
    post(K_CNT, "bytes_free_o", 8'(DEPTH), 8'(bytes_free_o));
    post(K_CNT, "bytes_available_o", 8'h00, 8'(bytes_available_o));
    check_status();

    // Register readback and the DLAB lockout
    bus_write(REG_SCR, 8'ha5);
    read_expect(REG_SCR, "SCR", model_scr, v);
    bus_write(REG_LCR, 8'h1b);
    read_expect(REG_LCR, "LCR", model_lcr, v);
    bus_write(REG_IER, 8'h05);
    read_expect(REG_IER, "IER", {4'h0, model_ier}, v);
    bus_write(REG_LCR, 8'h9b);
    bus_write(REG_IER, 8'h0a);
    read_expect(REG_IER, "IER", {4'h0, model_ier}, v);
    bus_write(REG_DATA, 8'h3c);
    repeat (8) @(negedge tck_i);
    post(K_CNT, "bytes_available_o", 8'h00, 8'(bytes_available_o));
    read_expect(REG_DATA, "PRDATA", 8'h00, v);
    bus_write(REG_LCR, 8'h03);
    read_expect(REG_LCR, "LCR", model_lcr, v);
    bus_write(REG_IER, 8'h00);
    read_expect(REG_IER, "IER", {4'h0, model_ier}, v);

    // Bus to debug
    for (i = 0; i < DEPTH; i++) begin
      bus_write(REG_DATA, 8'($random(seed)));
    end
    settle();
    drain_tx();

    // Debug to bus fills rx then polls it empty
    while (bytes_free_o != '0) begin
      rx_push(8'($random(seed)));
    end
    check_lsr(v);
    while (v[0]) begin
      read_expect(REG_DATA, "PRDATA", rx_q[0], v);
      rx_q.delete(0);
      check_lsr(v);
    end
    check_status();

    // Interrupts for rx data first and then transmit empty
    bus_write(REG_IER, 8'h01);
    rx_push(8'($random(seed)));
    check_status();
    read_expect(REG_DATA, "PRDATA", rx_q[0], v);
    rx_q.delete(0);
    bus_write(REG_DATA, 8'($random(seed)));
    drain_tx();
    bus_write(REG_IER, 8'h03);
    check_status();
    check_status();

    // FIFO flush with bytes queued both ways
    for (i = 0; i < 3; i++) begin
      bus_write(REG_DATA, 8'($random(seed)));
      rx_push(8'($random(seed)));
    end
    settle();
    bus_write(REG_IIR_FCR, 8'h06);
    check_status();
    settle();

    repeat (2) @(negedge PCLK);
    if (rd_idx == wr_idx) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      fail_run("Compare process left posted results unchecked");
    end
  end

endmodule

/* src.f */
+incdir+hw
hw/jsp_pkg.sv
hw/jsp_fifo_if.sv
hw/jsp_byte_fifo.sv
hw/jsp_tck_port.sv
hw/jsp_fifo_ctrl.sv
hw/jsp_uart_regs.sv
hw/jsp_bridge_top.sv
verification/jsp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the bridge testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module jsp_tb -f src.f -o jsp_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/jsp_sim > sim.log 2>&1 || true
cat sim.log
grep -qF "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; } \
  || grep -qF "*** TEST PASSED ***" sim.log \
  || { echo "Simulation ended without a result"; exit 1; }
